/* Bender.yml */
package:
  name: ptw

sources:
  - hw/ptw_pkg.sv
  - hw/ptw_cfg_regs.sv
  - hw/pte_checker.sv
  - hw/ptw_datapath.sv
  - hw/ptw_fsm.sv
  - hw/ptw_top.sv
  - target: test
    files:
      - bench/ptw_sva.sv
      - bench/ptw_scoreboard.sv
      - bench/ptw_tb.sv

/* all.f */
hw/ptw_pkg.sv
hw/ptw_cfg_regs.sv
hw/pte_checker.sv
hw/ptw_datapath.sv
hw/ptw_fsm.sv
hw/ptw_top.sv
bench/ptw_sva.sv
bench/ptw_scoreboard.sv
bench/ptw_tb.sv

/* bench/ptw_scoreboard.sv */
// Scoreboard comparing each walk result with the expected row values
`default_nettype none
`timescale 1ns/1ps

module ptw_scoreboard (
    input  wire logic                clk_i,
    input  wire logic                rst_ni,
    input  wire logic                walk_ack_i,
    input  wire logic                res_fault_i,
    input  wire ptw_pkg::cause_t     res_cause_i,
    input  wire ptw_pkg::ppn_t       res_ppn_i,
    input  wire ptw_pkg::page_size_e res_size_i,
    input  wire logic                res_global_i,
    input  wire ptw_pkg::pscid_t     res_pscid_i,
    input  wire logic [159:0]        test_name_i,
    input  wire logic                exp_fault_i,
    input  wire ptw_pkg::cause_t     exp_cause_i,
    input  wire ptw_pkg::ppn_t       exp_ppn_i,
    input  wire ptw_pkg::page_size_e exp_size_i,
    input  wire logic                exp_global_i,
    input  wire ptw_pkg::pscid_t     exp_pscid_i,
    output int                       pass_cnt_o,
    output int                       fail_cnt_o
);
    import ptw_pkg::*;

    logic        seen_q;
    logic [79:0] exp_vec;
    logic [79:0] act_vec;

    // Fault and cause always compared, the leaf fields only on a good walk
    assign exp_vec = exp_fault_i ? {1'b1, exp_cause_i, 67'd0}
                                 : {1'b0, 12'd0, exp_ppn_i, exp_size_i,
                                    exp_global_i, exp_pscid_i};
    assign act_vec = exp_fault_i ? {res_fault_i, res_cause_i, 67'd0}
                                 : {res_fault_i, res_cause_i, res_ppn_i, res_size_i,
                                    res_global_i, res_pscid_i};

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            seen_q     <= 1'b0;
            pass_cnt_o <= 0;
            fail_cnt_o <= 0;
        end else begin
            seen_q <= walk_ack_i;
            // One comparison per acknowledge, on its first cycle
            if (walk_ack_i && !seen_q) begin
                if (act_vec === exp_vec) begin
                    $display("ok     %0s", test_name_i);
                    pass_cnt_o <= pass_cnt_o + 1;
                end else begin
                    $display("FAILED %0s expected %h actual %h",
                             test_name_i, exp_vec, act_vec);
                    fail_cnt_o <= fail_cnt_o + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* bench/ptw_sva.sv */
// Handshake and reset assertions for the page table walker top level
`default_nettype none
`timescale 1ns/1ps

module ptw_sva (
    input wire logic            clk_i,
    input wire logic            rst_ni,
    input wire logic            walk_req_i,
    input wire logic            walk_ack_o,
    input wire logic            mem_req_o,
    input wire logic            mem_ack_i,
    input wire ptw_pkg::paddr_t mem_addr_o
);

    // Count of failed assertions
    int unsigned assert_fail_cnt;

    // Address held for as long as the read request stays up
    mem_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o && $past(mem_req_o) |-> $stable(mem_addr_o))
        else begin
            assert_fail_cnt++;
            $error("mem_addr_o changed while mem_req_o was high");
        end

    // New read only after the memory has released its acknowledge
    mem_req_after_ack_low: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(mem_req_o) |-> !mem_ack_i)
        else begin
            assert_fail_cnt++;
            $error("mem_req_o rose while mem_ack_i was still high");
        end

    // Walk acknowledge released only once the request has gone
    walk_ack_release: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $fell(walk_ack_o) |-> !$past(walk_req_i))
        else begin
            assert_fail_cnt++;
            $error("walk_ack_o fell while walk_req_i was still high");
        end

    // Both acknowledge outputs low on the first cycle out of reset
    reset_quiet: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> !walk_ack_o && !mem_req_o)
        else begin
            assert_fail_cnt++;
            $error("walk_ack_o or mem_req_o high when leaving reset");
        end

endmodule

bind ptw_top ptw_sva i_ptw_sva (.*);

`default_nettype wire

/* bench/ptw_tb.sv */
// Testbench for the page table walker with memory model and stimulus table
`default_nettype none
`timescale 1ns/1ps

module ptw_tb;
    import ptw_pkg::*;

    localparam int MAX_ROWS  = 32;
    localparam int RESET_LEN = 16;
    localparam ppn_t ROOT_A  = 44'h80000;
    localparam ppn_t ROOT_B  = 44'h90000;

    // Flag combinations used in the tables
    localparam logic [9:0] F_PTR   = 10'h001;
    localparam logic [9:0] F_LEAF  = 10'h0c7;

    logic       clk_i;
    logic       rst_ni;
    logic       walk_req_i;
    vaddr_t     walk_iova_i;
    logic       walk_store_i;
    logic       walk_ack_o;
    logic       res_fault_o;
    cause_t     res_cause_o;
    ppn_t       res_ppn_o;
    page_size_e res_size_o;
    logic       res_global_o;
    pscid_t     res_pscid_o;
    logic       mem_req_o;
    paddr_t     mem_addr_o;
    logic       mem_ack_i;
    pte_t       mem_rdata_i;
    logic       mem_err_i;
    logic       cfg_we_i;
    logic       cfg_addr_i;
    ppn_t       cfg_wdata_i;

    // Stimulus table, cfg mode 0 none, 1 before the walk, 2 during it
    logic [159:0] row_name [MAX_ROWS];
    vaddr_t       row_iova [MAX_ROWS];
    logic         row_store [MAX_ROWS];
    int           row_cfg_mode [MAX_ROWS];
    logic         row_cfg_addr [MAX_ROWS];
    ppn_t         row_cfg_data [MAX_ROWS];
    logic         row_fault [MAX_ROWS];
    cause_t       row_cause [MAX_ROWS];
    ppn_t         row_ppn [MAX_ROWS];
    page_size_e   row_size [MAX_ROWS];
    logic         row_global [MAX_ROWS];
    int           n_rows;

    logic [159:0] test_name;
    logic         exp_fault;
    cause_t       exp_cause;
    ppn_t         exp_ppn;
    page_size_e   exp_size;
    logic         exp_global;
    pscid_t       exp_pscid;
    pscid_t       pscid_model;
    int           pass_cnt;
    int           fail_cnt;

    // Memory model contents
    pte_t         mem [paddr_t];
    bit           mem_bad [paddr_t];
    int unsigned  wait_cnt;

    int           cycle_cnt;
    int           cycle_limit;

    ptw_top #(
        .RESET_ROOT_PPN(ROOT_A)
    ) i_ptw_top (.*);

    ptw_scoreboard i_ptw_scoreboard (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .walk_ack_i  (walk_ack_o),
        .res_fault_i (res_fault_o),
        .res_cause_i (res_cause_o),
        .res_ppn_i   (res_ppn_o),
        .res_size_i  (res_size_o),
        .res_global_i(res_global_o),
        .res_pscid_i (res_pscid_o),
        .test_name_i (test_name),
        .exp_fault_i (exp_fault),
        .exp_cause_i (exp_cause),
        .exp_ppn_i   (exp_ppn),
        .exp_size_i  (exp_size),
        .exp_global_i(exp_global),
        .exp_pscid_i (exp_pscid),
        .pass_cnt_o  (pass_cnt),
        .fail_cnt_o  (fail_cnt)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic vaddr_t mk_iova(input int vpn2, input int vpn1, input int vpn0);
        return vaddr_t'(vpn2) * 39'h4000_0000 + vaddr_t'(vpn1) * 39'h20_0000
             + vaddr_t'(vpn0) * 39'h1000 + 39'h5a8;
    endfunction

    function automatic pte_t mk_pte(input ppn_t ppn, input logic [9:0] flags);
        return (pte_t'(ppn) << 10) | pte_t'(flags);
    endfunction

    // Entry address is table page times 4096 plus index times 8
    function automatic paddr_t entry_addr(input ppn_t table_ppn, input int vpn);
        return paddr_t'(table_ppn) * 4096 + paddr_t'(vpn) * 8;
    endfunction

    task automatic put_pte(input ppn_t table_ppn, input int vpn, input pte_t pte);
        mem[entry_addr(table_ppn, vpn)] = pte;
    endtask

    task automatic add_row(input logic [159:0] name, input vaddr_t iova, input logic store,
                           input int cfg_mode, input logic cfg_addr, input ppn_t cfg_data,
                           input logic fault, input cause_t cause, input ppn_t ppn,
                           input page_size_e size, input logic glob);
        row_name[n_rows]     = name;
        row_iova[n_rows]     = iova;
        row_store[n_rows]    = store;
        row_cfg_mode[n_rows] = cfg_mode;
        row_cfg_addr[n_rows] = cfg_addr;
        row_cfg_data[n_rows] = cfg_data;
        row_fault[n_rows]    = fault;
        row_cause[n_rows]    = cause;
        row_ppn[n_rows]      = ppn;
        row_size[n_rows]     = size;
        row_global[n_rows]   = glob;
        n_rows++;
    endtask

    task automatic build_tables;
        // Tree A under the reset root
        put_pte(ROOT_A, 0, mk_pte(44'h80001, F_PTR));
        put_pte(ROOT_A, 1, mk_pte(44'h40000, F_LEAF));
        put_pte(ROOT_A, 2, mk_pte(44'h80003, 10'h041));
        put_pte(ROOT_A, 3, mk_pte(44'h80004, 10'h021));
        put_pte(44'h80001, 0, mk_pte(44'h80002, F_PTR));
        put_pte(44'h80001, 1, mk_pte(44'h200, F_LEAF));
        put_pte(44'h80001, 2, mk_pte(44'h201, F_LEAF));
        put_pte(44'h80002, 1, mk_pte(44'h12345, F_LEAF));
        put_pte(44'h80002, 3, mk_pte(44'h333, 10'h0c5));
        put_pte(44'h80002, 4, mk_pte(44'h444, F_LEAF) | (64'h1 << 60));
        put_pte(44'h80002, 5, mk_pte(44'h111, 10'h087));
        put_pte(44'h80002, 6, mk_pte(44'h222, 10'h043));
        put_pte(44'h80002, 7, mk_pte(44'h80005, F_PTR));
        put_pte(44'h80004, 0, mk_pte(44'h400, F_LEAF));
        mem_bad[entry_addr(44'h80002, 8)] = 1'b1;
        // Tree B holds a single 1G page
        put_pte(ROOT_B, 0, mk_pte(44'hc0000, F_LEAF));
    endtask

    task automatic build_rows;
        n_rows = 0;
        add_row("4k_load", mk_iova(0, 0, 1), 0, 0, 0, 0, 0, 0, 44'h12345, SIZE_4K, 0);
        add_row("4k_store", mk_iova(0, 0, 1), 1, 0, 0, 0, 0, 0, 44'h12345, SIZE_4K, 0);
        add_row("1g_leaf", mk_iova(1, 5, 7), 0, 0, 0, 0, 0, 0, 44'h40a07, SIZE_1G, 0);
        add_row("2m_leaf", mk_iova(0, 1, 3), 1, 0, 0, 0, 0, 0, 44'h203, SIZE_2M, 0);
        add_row("v_clear", mk_iova(0, 0, 2), 0, 0, 0, 0, 1, 13, 0, SIZE_4K, 0);
        add_row("w_without_r", mk_iova(0, 0, 3), 1, 0, 0, 0, 1, 15, 0, SIZE_4K, 0);
        add_row("reserved_bits", mk_iova(0, 0, 4), 0, 0, 0, 0, 1, 13, 0, SIZE_4K, 0);
        add_row("misaligned_2m", mk_iova(0, 2, 0), 0, 0, 0, 0, 1, 13, 0, SIZE_4K, 0);
        add_row("a_clear", mk_iova(0, 0, 5), 1, 0, 0, 0, 1, 15, 0, SIZE_4K, 0);
        add_row("d_clear_store", mk_iova(0, 0, 6), 1, 0, 0, 0, 1, 15, 0, SIZE_4K, 0);
        add_row("d_clear_load", mk_iova(0, 0, 6), 0, 0, 0, 0, 0, 0, 44'h222, SIZE_4K, 0);
        add_row("pointer_adu", mk_iova(2, 0, 0), 0, 0, 0, 0, 1, 13, 0, SIZE_4K, 0);
        add_row("pointer_lvl3", mk_iova(0, 0, 7), 1, 0, 0, 0, 1, 15, 0, SIZE_4K, 0);
        add_row("bus_err_load", mk_iova(0, 0, 8), 0, 0, 0, 0, 1, 268, 0, SIZE_4K, 0);
        add_row("bus_err_store", mk_iova(0, 0, 8), 1, 0, 0, 0, 1, 268, 0, SIZE_4K, 0);
        add_row("pscid_write", mk_iova(0, 0, 1), 0, 1, 1, 44'habcde,
                0, 0, 44'h12345, SIZE_4K, 0);
        add_row("global_pointer", mk_iova(3, 0, 9), 0, 0, 0, 0, 0, 0, 44'h409, SIZE_2M, 1);
        add_row("root_write_busy", mk_iova(0, 0, 1), 0, 2, 0, ROOT_B,
                0, 0, 44'h12345, SIZE_4K, 0);
        add_row("root_kept", mk_iova(0, 0, 1), 0, 0, 0, 0, 0, 0, 44'h12345, SIZE_4K, 0);
        add_row("root_write_idle", mk_iova(0, 0, 1), 0, 1, 0, ROOT_B,
                0, 0, 44'hc0001, SIZE_1G, 0);
    endtask

    // Memory responds after 0 to 3 idle cycles and releases once the request drops
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mem_ack_i   <= 1'b0;
            mem_rdata_i <= '0;
            mem_err_i   <= 1'b0;
            wait_cnt    <= 0;
        end else if (mem_req_o && !mem_ack_i) begin
            if (wait_cnt == 0) begin
                mem_ack_i   <= 1'b1;
                mem_rdata_i <= mem.exists(mem_addr_o) ? mem[mem_addr_o] : '0;
                mem_err_i   <= mem_bad.exists(mem_addr_o);
                wait_cnt    <= $urandom % 4;
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end else if (mem_ack_i && !mem_req_o) begin
            mem_ack_i <= 1'b0;
            mem_err_i <= 1'b0;
        end
    end

    // Run limit scales with the table length
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, the walk never completed", cycle_cnt);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h0ff2cb48));
        rst_ni       = 1'b0;
        walk_req_i   = 1'b0;
        walk_iova_i  = '0;
        walk_store_i = 1'b0;
        cfg_we_i     = 1'b0;
        cfg_addr_i   = 1'b0;
        cfg_wdata_i  = '0;
        test_name    = '0;
        exp_fault    = 1'b0;
        exp_cause    = '0;
        exp_ppn      = '0;
        exp_size     = SIZE_4K;
        exp_global   = 1'b0;
        exp_pscid    = '0;
        pscid_model  = '0;
        cycle_cnt    = 0;
        build_tables();
        build_rows();
        cycle_limit = n_rows * 3 * 20 + RESET_LEN;

        repeat (RESET_LEN) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(posedge clk_i);

        for (int i = 0; i < n_rows; i++) begin
            if (row_cfg_mode[i] == 1) begin
                cfg_we_i    <= 1'b1;
                cfg_addr_i  <= row_cfg_addr[i];
                cfg_wdata_i <= row_cfg_data[i];
                // Writes while idle land, PSCID keeps its low 20 bits
                if (row_cfg_addr[i] == CFG_ADDR_PSCID) begin
                    pscid_model = row_cfg_data[i][19:0];
                end
                @(posedge clk_i);
                cfg_we_i <= 1'b0;
            end
            test_name    <= row_name[i];
            exp_fault    <= row_fault[i];
            exp_cause    <= row_cause[i];
            exp_ppn      <= row_ppn[i];
            exp_size     <= row_size[i];
            exp_global   <= row_global[i];
            exp_pscid    <= pscid_model;
            walk_iova_i  <= row_iova[i];
            walk_store_i <= row_store[i];
            walk_req_i   <= 1'b1;
            if (row_cfg_mode[i] == 2) begin
                // Walker has left IDLE by the time this write is seen
                @(posedge clk_i);
                cfg_we_i    <= 1'b1;
                cfg_addr_i  <= row_cfg_addr[i];
                cfg_wdata_i <= row_cfg_data[i];
                @(posedge clk_i);
                cfg_we_i <= 1'b0;
            end
            do begin
                @(posedge clk_i);
            end while (!walk_ack_o);
            walk_req_i <= 1'b0;
            do begin
                @(posedge clk_i);
            end while (walk_ack_o);
        end

        repeat (2) @(posedge clk_i);
        $display("Walks checked %0d of %0d, %0d passed, %0d failed, %0d assertion failures",
                 pass_cnt + fail_cnt, n_rows, pass_cnt, fail_cnt,
                 i_ptw_top.i_ptw_sva.assert_fail_cnt);
        if (fail_cnt == 0 && pass_cnt == n_rows
            && i_ptw_top.i_ptw_sva.assert_fail_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/pte_checker.sv */
// Sv39 PTE classifier sorting one fetched entry into leaf, pointer or fault
`default_nettype none
`timescale 1ns/1ps

module pte_checker (
    input  ptw_pkg::pte_t       pte_i,
    input  ptw_pkg::walk_lvl_e  lvl_i,
    input  logic                store_i,
    input  logic                bus_err_i,
    output ptw_pkg::pte_class_e class_o,
    output logic                corrupt_o
);
    import ptw_pkg::*;

    ppn_t pte_ppn;
    logic is_leaf;
    logic bad_encoding;
    logic bad_leaf;
    logic bad_pointer;
    logic misaligned;

    assign pte_ppn = pte_i[RSVD_LSB-1:PPN_LSB];

    // Any of R or X marks a leaf, otherwise a pointer to the next table
    assign is_leaf = pte_i[PTE_R_BIT] || pte_i[PTE_X_BIT];

    // Invalid, W without R, or reserved upper bits in use
    assign bad_encoding = !pte_i[PTE_V_BIT]
                       || (pte_i[PTE_W_BIT] && !pte_i[PTE_R_BIT])
                       || (|pte_i[PTE_W-1:RSVD_LSB]);

    // Superpage leaves need zero low PPN bits
    assign misaligned = ((lvl_i == LVL1) && (|pte_ppn[2*VPN_W-1:0]))
                     || ((lvl_i == LVL2) && (|pte_ppn[VPN_W-1:0]));

    // Leaf needs A and R set, and D set when written
    assign bad_leaf = is_leaf && (misaligned
                                  || !pte_i[PTE_A_BIT]
                                  || !pte_i[PTE_R_BIT]
                                  || (store_i && !pte_i[PTE_D_BIT]));

    // A, D and U are reserved on pointers; a pointer at LVL3 runs out of levels
    assign bad_pointer = !is_leaf && (pte_i[PTE_A_BIT]
                                      || pte_i[PTE_D_BIT]
                                      || pte_i[PTE_U_BIT]
                                      || (lvl_i == LVL3));

    always_comb begin
        if (bus_err_i || bad_encoding || bad_leaf || bad_pointer) begin
            class_o = PTE_FAULT;
        end else if (is_leaf) begin
            class_o = PTE_LEAF;
        end else begin
            class_o = PTE_POINTER;
        end
    end

    // Read errors are reported as page table data corruption
    assign corrupt_o = bus_err_i;

endmodule

`default_nettype wire

/* hw/ptw_cfg_regs.sv */
// Walker configuration registers holding root page number and process context ID
`default_nettype none
`timescale 1ns/1ps

module ptw_cfg_regs #(
    parameter ptw_pkg::ppn_t RESET_ROOT_PPN = '0
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            cfg_we_i,
    input  logic            cfg_addr_i,
    input  ptw_pkg::ppn_t   cfg_wdata_i,
    input  logic            walk_busy_i,
    output ptw_pkg::ppn_t   root_ppn_o,
    output ptw_pkg::pscid_t pscid_o
);
    import ptw_pkg::*;

    ppn_t   root_q;
    pscid_t pscid_q;
    logic   wr_en;

    // Writes are dropped for the whole walk so root and context stay consistent
    assign wr_en = cfg_we_i && !walk_busy_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            root_q  <= RESET_ROOT_PPN;
            pscid_q <= '0;
        end else if (wr_en) begin
            if (cfg_addr_i == CFG_ADDR_ROOT) begin
                root_q <= cfg_wdata_i;
            end
            // Context ID sits in the low bits of the write data
            if (cfg_addr_i == CFG_ADDR_PSCID) begin
                pscid_q <= cfg_wdata_i[PSCID_W-1:0];
            end
        end
    end

    assign root_ppn_o = root_q;
    assign pscid_o    = pscid_q;

endmodule

`default_nettype wire

/* hw/ptw_datapath.sv */
// Walker datapath with walk registers, table pointer generation and leaf PPN merge
`default_nettype none
`timescale 1ns/1ps

module ptw_datapath (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                start_walk_i,
    input  logic                capture_pte_i,
    input  ptw_pkg::walk_lvl_e  lvl_i,
    input  ptw_pkg::vaddr_t     iova_i,
    input  ptw_pkg::ppn_t       root_ppn_i,
    input  ptw_pkg::pscid_t     pscid_i,
    input  ptw_pkg::pte_t       mem_rdata_i,
    output ptw_pkg::paddr_t     mem_addr_o,
    output ptw_pkg::pte_t       pte_o,
    output ptw_pkg::ppn_t       res_ppn_o,
    output ptw_pkg::page_size_e res_size_o,
    output logic                res_global_o,
    output ptw_pkg::pscid_t     res_pscid_o
);
    import ptw_pkg::*;

    vaddr_t     iova_q;
    pscid_t     pscid_q;
    pte_t       pte_q;
    pte_t       pte_cur;
    paddr_t     addr_q;
    ppn_t       ppn_q;
    ppn_t       pte_ppn;
    ppn_t       leaf_ppn;
    page_size_e size_q;
    page_size_e leaf_size;
    logic       global_q;
    vpn_idx_t   root_vpn;
    vpn_idx_t   vpn1;
    vpn_idx_t   vpn0;
    vpn_idx_t   next_vpn;

    // Bypass so the entry is visible on the same cycle it arrives
    assign pte_cur = capture_pte_i ? mem_rdata_i : pte_q;
    assign pte_ppn = pte_cur[RSVD_LSB-1:PPN_LSB];

    // VPN[2] from the incoming request, lower VPNs from the held IOVA
    assign root_vpn = iova_i[PAGE_OFFSET_W+2*VPN_W +: VPN_W];
    assign vpn1     = iova_q[PAGE_OFFSET_W+VPN_W +: VPN_W];
    assign vpn0     = iova_q[PAGE_OFFSET_W +: VPN_W];

    always_comb begin
        next_vpn  = vpn0;
        leaf_ppn  = pte_ppn;
        leaf_size = SIZE_4K;
        case (lvl_i)
            LVL1: begin
                // 1G page keeps VPN[1] and VPN[0] from the IOVA
                next_vpn       = vpn1;
                leaf_ppn[2*VPN_W-1:0] = {vpn1, vpn0};
                leaf_size      = SIZE_1G;
            end
            LVL2: begin
                leaf_ppn[VPN_W-1:0] = vpn0;
                leaf_size      = SIZE_2M;
            end
            default: begin
                leaf_size = SIZE_4K;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (start_walk_i) begin
            iova_q  <= iova_i;
            pscid_q <= pscid_i;
            // Entries are 8 bytes wide
            addr_q  <= {root_ppn_i, root_vpn, 3'b000};
        end else if (capture_pte_i) begin
            pte_q  <= mem_rdata_i;
            addr_q <= {pte_ppn, next_vpn, 3'b000};
            ppn_q  <= leaf_ppn;
        end
    end

    // Global bit accumulates over every entry of the walk
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            global_q <= 1'b0;
            size_q   <= SIZE_4K;
        end else if (start_walk_i) begin
            global_q <= 1'b0;
        end else if (capture_pte_i) begin
            global_q <= global_q | pte_cur[PTE_G_BIT];
            size_q   <= leaf_size;
        end
    end

    assign mem_addr_o   = addr_q;
    assign pte_o        = pte_cur;
    assign res_ppn_o    = ppn_q;
    assign res_size_o   = size_q;
    assign res_global_o = global_q;
    assign res_pscid_o  = pscid_q;

endmodule

`default_nettype wire

/* hw/ptw_fsm.sv */
// Walk controller FSM running the walk and memory four-phase handshakes
`default_nettype none
`timescale 1ns/1ps

module ptw_fsm (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                walk_req_i,
    input  logic                walk_store_i,
    input  logic                mem_ack_i,
    input  logic                mem_err_i,
    input  ptw_pkg::pte_class_e class_i,
    input  logic                corrupt_i,
    output logic                walk_ack_o,
    output logic                res_fault_o,
    output ptw_pkg::cause_t     res_cause_o,
    output logic                mem_req_o,
    output logic                start_walk_o,
    output logic                capture_pte_o,
    output ptw_pkg::walk_lvl_e  lvl_o,
    output logic                walk_busy_o
);
    import ptw_pkg::*;

    ptw_state_e state_q;
    ptw_state_e state_d;
    walk_lvl_e  lvl_q;
    walk_lvl_e  lvl_d;
    pte_class_e class_q;
    pte_class_e class_d;
    logic       corrupt_q;
    logic       corrupt_d;
    logic       store_q;
    logic       store_d;
    logic       ack_q;
    logic       ack_d;
    logic       result_state;
    logic       release_walk;

    assign result_state = (state_q == DONE) || (state_q == FAULT);

    // Requester dropped its request after seeing the acknowledge
    assign release_walk = ack_q && !walk_req_i;

    always_comb begin
        state_d       = state_q;
        lvl_d         = lvl_q;
        class_d       = class_q;
        corrupt_d     = corrupt_q;
        store_d       = store_q;
        start_walk_o  = 1'b0;
        capture_pte_o = 1'b0;

        case (state_q)
            IDLE: begin
                // Request inputs are sampled only here
                if (walk_req_i) begin
                    state_d      = MEM_REQ;
                    lvl_d        = LVL1;
                    store_d      = walk_store_i;
                    corrupt_d    = 1'b0;
                    start_walk_o = 1'b1;
                end
            end
            MEM_REQ: begin
                if (mem_ack_i) begin
                    // Skip the register update on a failed read
                    capture_pte_o = !mem_err_i;
                    class_d       = class_i;
                    corrupt_d     = corrupt_i;
                    state_d       = MEM_WAIT;
                end
            end
            MEM_WAIT: begin
                // Next request only once the memory has dropped its ack
                if (!mem_ack_i) begin
                    case (class_q)
                        PTE_POINTER: begin
                            state_d = MEM_REQ;
                            lvl_d   = (lvl_q == LVL1) ? LVL2 : LVL3;
                        end
                        PTE_LEAF: begin
                            state_d = DONE;
                        end
                        default: begin
                            state_d = FAULT;
                        end
                    endcase
                end
            end
            DONE, FAULT: begin
                if (release_walk) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // Ack rises one cycle after DONE or FAULT is entered
    assign ack_d = result_state && !release_walk;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= IDLE;
            lvl_q     <= LVL1;
            class_q   <= PTE_POINTER;
            corrupt_q <= 1'b0;
            store_q   <= 1'b0;
            ack_q     <= 1'b0;
        end else begin
            state_q   <= state_d;
            lvl_q     <= lvl_d;
            class_q   <= class_d;
            corrupt_q <= corrupt_d;
            store_q   <= store_d;
            ack_q     <= ack_d;
        end
    end

    // Bus errors take priority over the access type fault
    always_comb begin
        res_cause_o = '0;
        if (state_q == FAULT) begin
            if (corrupt_q) begin
                res_cause_o = CAUSE_PT_CORRUPT;
            end else if (store_q) begin
                res_cause_o = CAUSE_STORE_PF;
            end else begin
                res_cause_o = CAUSE_LOAD_PF;
            end
        end
    end

    assign walk_ack_o  = ack_q;
    assign res_fault_o = (state_q == FAULT);
    assign mem_req_o   = (state_q == MEM_REQ);
    assign lvl_o       = lvl_q;
    assign walk_busy_o = (state_q != IDLE);

endmodule

`default_nettype wire

/* hw/ptw_pkg.sv */
// Sv39 page table walker shared widths, types, PTE bit positions and fault causes
`default_nettype none

package ptw_pkg;

    // Sv39 address and entry widths
    localparam int unsigned VLEN          = 39;
    localparam int unsigned PPN_W         = 44;
    localparam int unsigned PLEN          = 56;
    localparam int unsigned PTE_W         = 64;
    localparam int unsigned VPN_W         = 9;
    localparam int unsigned PAGE_OFFSET_W = 12;
    localparam int unsigned PSCID_W       = 20;
    localparam int unsigned CAUSE_W       = 12;

    typedef logic [VLEN-1:0]    vaddr_t;
    typedef logic [PPN_W-1:0]   ppn_t;
    typedef logic [PLEN-1:0]    paddr_t;
    typedef logic [PTE_W-1:0]   pte_t;
    typedef logic [VPN_W-1:0]   vpn_idx_t;
    typedef logic [PSCID_W-1:0] pscid_t;
    typedef logic [CAUSE_W-1:0] cause_t;

    // PTE flag bit positions
    localparam int unsigned PTE_V_BIT = 0;
    localparam int unsigned PTE_R_BIT = 1;
    localparam int unsigned PTE_W_BIT = 2;
    localparam int unsigned PTE_X_BIT = 3;
    localparam int unsigned PTE_U_BIT = 4;
    localparam int unsigned PTE_G_BIT = 5;
    localparam int unsigned PTE_A_BIT = 6;
    localparam int unsigned PTE_D_BIT = 7;

    // PPN occupies bits 53:10, bits 63:54 are reserved
    localparam int unsigned PPN_LSB  = 10;
    localparam int unsigned RSVD_LSB = 54;

    // IOMMU fault cause codes
    localparam cause_t CAUSE_LOAD_PF    = 12'd13;
    localparam cause_t CAUSE_STORE_PF   = 12'd15;
    localparam cause_t CAUSE_PT_CORRUPT = 12'd268;

    typedef enum logic [1:0] {SIZE_4K, SIZE_2M, SIZE_1G} page_size_e;

    // LVL1 is the root table
    typedef enum logic [1:0] {LVL1, LVL2, LVL3} walk_lvl_e;

    typedef enum logic [2:0] {IDLE, MEM_REQ, MEM_WAIT, DONE, FAULT} ptw_state_e;

    typedef enum logic [1:0] {PTE_POINTER, PTE_LEAF, PTE_FAULT} pte_class_e;

    // Configuration register map
    localparam logic CFG_ADDR_ROOT  = 1'b0;
    localparam logic CFG_ADDR_PSCID = 1'b1;

endpackage

`default_nettype wire

/* hw/ptw_top.sv */
// Sv39 page table walker top level joining config, controller, datapath and checker
`default_nettype none
`timescale 1ns/1ps

module ptw_top #(
    parameter ptw_pkg::ppn_t RESET_ROOT_PPN = 44'h80000
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    // Walk request port
    input  logic                walk_req_i,
    input  ptw_pkg::vaddr_t     walk_iova_i,
    input  logic                walk_store_i,
    output logic                walk_ack_o,
    // Walk result
    output logic                res_fault_o,
    output ptw_pkg::cause_t     res_cause_o,
    output ptw_pkg::ppn_t       res_ppn_o,
    output ptw_pkg::page_size_e res_size_o,
    output logic                res_global_o,
    output ptw_pkg::pscid_t     res_pscid_o,
    // Memory read port
    output logic                mem_req_o,
    output ptw_pkg::paddr_t     mem_addr_o,
    input  logic                mem_ack_i,
    input  ptw_pkg::pte_t       mem_rdata_i,
    input  logic                mem_err_i,
    // Configuration write port
    input  logic                cfg_we_i,
    input  logic                cfg_addr_i,
    input  ptw_pkg::ppn_t       cfg_wdata_i
);
    import ptw_pkg::*;

    ppn_t       root_ppn;
    pscid_t     pscid;
    logic       walk_busy;
    logic       start_walk;
    logic       capture_pte;
    walk_lvl_e  lvl;
    pte_t       pte;
    pte_class_e pte_class;
    logic       pte_corrupt;

    ptw_cfg_regs #(
        .RESET_ROOT_PPN(RESET_ROOT_PPN)
    ) i_ptw_cfg_regs (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .cfg_we_i   (cfg_we_i),
        .cfg_addr_i (cfg_addr_i),
        .cfg_wdata_i(cfg_wdata_i),
        .walk_busy_i(walk_busy),
        .root_ppn_o (root_ppn),
        .pscid_o    (pscid)
    );

    ptw_fsm i_ptw_fsm (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .walk_req_i   (walk_req_i),
        .walk_store_i (walk_store_i),
        .mem_ack_i    (mem_ack_i),
        .mem_err_i    (mem_err_i),
        .class_i      (pte_class),
        .corrupt_i    (pte_corrupt),
        .walk_ack_o   (walk_ack_o),
        .res_fault_o  (res_fault_o),
        .res_cause_o  (res_cause_o),
        .mem_req_o    (mem_req_o),
        .start_walk_o (start_walk),
        .capture_pte_o(capture_pte),
        .lvl_o        (lvl),
        .walk_busy_o  (walk_busy)
    );

    ptw_datapath i_ptw_datapath (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .start_walk_i (start_walk),
        .capture_pte_i(capture_pte),
        .lvl_i        (lvl),
        .iova_i       (walk_iova_i),
        .root_ppn_i   (root_ppn),
        .pscid_i      (pscid),
        .mem_rdata_i  (mem_rdata_i),
        .mem_addr_o   (mem_addr_o),
        .pte_o        (pte),
        .res_ppn_o    (res_ppn_o),
        .res_size_o   (res_size_o),
        .res_global_o (res_global_o),
        .res_pscid_o  (res_pscid_o)
    );

    // Store flag is held stable by the requester for the whole walk
    pte_checker i_pte_checker (
        .pte_i    (pte),
        .lvl_i    (lvl),
        .store_i  (walk_store_i),
        .bus_err_i(mem_err_i),
        .class_o  (pte_class),
        .corrupt_o(pte_corrupt)
    );

endmodule

`default_nettype wire
